// ==== stageD.f ====
decodePkg.sv
decodeCtrlIf.sv
controlDecoder.sv
immExtend.sv
regFile.sv
stageD.sv
stageD_assert.sv
tbStageD.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbStageD
FILELIST  ?= stageD.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '^>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q '^>>> PASS' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tbStageD.sv ====
`timescale 1ns/1ps

module tbStageD;
  import decodePkg::*;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memSigned;
    logic       illegal;
    aluSrc_t    aluSrc;
    branch_t    branch;
    memSize_t   memSize;
    aluCtrl_t   aluControl;
    resultSrc_t resultSrc;
  } ctrlSet_t;

  localparam int timeoutCycles = 2000;  // Roughly 250 cycles of tests, wide margin

  logic clk, rstN, stallD, flushD, regWriteW;
  word_t instrF, pcF, pcPlus4F, resultW;
  regAddr_t rdW;
  word_t rd1D, rd2D, immExtD, pcD, pcPlus4D;
  regAddr_t rs1D, rs2D, rdD;
  logic regWriteD, memWriteD, memSignedD, illegalD;
  aluSrc_t aluSrcD;
  branch_t branchD;
  memSize_t memSizeD;
  aluCtrl_t aluControlD;
  resultSrc_t resultSrcD;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  word_t rngState = 32'h47144f49;
  word_t pcCur = 32'h0000_1000;
  word_t expRegs [32];                   // Register file model

  stageD stageD_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    while (cycles < timeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
    $display(">>> FAIL");
    $finish;
  end

  function word_t xorshift32();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // RV32I encoders
  function word_t rType(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1, logic [2:0] f3,
                        regAddr_t rd);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function word_t iType(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3, regAddr_t rd,
                        logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function word_t sType(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
  endfunction

  function word_t bType(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function word_t uType(logic [19:0] upper, regAddr_t rd, logic [6:0] op);
    return {upper, rd, op};
  endfunction

  function word_t jType(logic [20:0] imm, regAddr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
  endfunction

  // Flags are regWrite, memWrite, memSigned, illegal
  function ctrlSet_t mkCtrl(logic [3:0] flags, aluSrc_t src, branch_t br, memSize_t size,
                            aluCtrl_t alu, resultSrc_t res);
    return {flags, src, br, size, alu, res};
  endfunction

  function ctrlSet_t ctrlNow();
    return {regWriteD, memWriteD, memSignedD, illegalD, aluSrcD, branchD, memSizeD,
            aluControlD, resultSrcD};
  endfunction

  task checkWord(word_t got, word_t exp, string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task checkReg(regAddr_t got, regAddr_t exp, string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got x%0d expected x%0d", $time, msg, got, exp);
    end
  endtask

  task checkCtrl(ctrlSet_t got, ctrlSet_t exp, string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s controls, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task checkBubble(string msg);
    checkCtrl(ctrlNow(), '0, msg);
    checkWord(pcD, '0, {msg, " pcD"});
    checkWord(pcPlus4D, '0, {msg, " pcPlus4D"});
  endtask

  task endTest(string name, int start);
    if (errors == start) $display("test %-12s ok", name);
    else $display("test %-12s %0d errors", name, errors - start);
  endtask

  // Drive one fetch, return at the edge that captures it
  task present(word_t instr);
    @(posedge clk);
    pcCur = pcCur + 32'd4;
    instrF <= instr;
    pcF <= pcCur;
    pcPlus4F <= pcCur + 32'd4;
    @(posedge clk);
  endtask

  task settle();
    @(negedge clk);
    #1;                                  // Past the register file write
  endtask

  task decodeOne(word_t instr, ctrlSet_t exp, string name);
    present(instr);
    settle();
    checkCtrl(ctrlNow(), exp, name);
    checkReg(rdD, instr[11:7], {name, " rdD"});
    checkReg(rs1D, instr[19:15], {name, " rs1D"});
    checkReg(rs2D, instr[24:20], {name, " rs2D"});
    checkWord(pcD, pcCur, {name, " pcD"});
    checkWord(pcPlus4D, pcCur + 32'd4, {name, " pcPlus4D"});
  endtask

  task immOne(word_t instr, word_t exp, string name);
    present(instr);
    settle();
    checkWord(immExtD, exp, name);
  endtask

  task testReset();
    int start;
    start = errors;
    repeat (4) @(posedge clk);
    #1;
    checkBubble("during reset");
    @(posedge clk);
    rstN <= 1'b1;
    settle();
    checkBubble("after reset");
    endTest("reset", start);
  endtask

  task testRegFile();
    int start;
    word_t v;
    start = errors;
    for (int i = 0; i < 32; i++) begin
      v = xorshift32();
      @(posedge clk);
      regWriteW <= 1'b1;
      rdW <= regAddr_t'(i);
      resultW <= v;
      expRegs[i] = (i == 0) ? '0 : v;    // x0 write is dropped
    end
    @(posedge clk);
    regWriteW <= 1'b0;
    for (int i = 0; i < 32; i++) begin
      present(rType(7'h00, regAddr_t'(31 - i), regAddr_t'(i), 3'b000, 5'd1));
      settle();
      checkWord(rd1D, expRegs[i], $sformatf("rd1D x%0d", i));
      checkWord(rd2D, expRegs[31 - i], $sformatf("rd2D x%0d", 31 - i));
    end
    // Writeback lands in the same cycle as the read
    v = xorshift32();
    present(rType(7'h00, 5'd6, 5'd5, 3'b000, 5'd7));
    regWriteW <= 1'b1;
    rdW <= 5'd5;
    resultW <= v;
    settle();
    checkWord(rd1D, v, "same cycle write x5");
    checkWord(rd2D, expRegs[6], "neighbour x6");
    @(posedge clk);
    regWriteW <= 1'b0;
    endTest("regFile", start);
  endtask

  task testControl();
    int start;
    start = errors;
    decodeOne(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3),
              mkCtrl(4'b1000, 2'b00, 2'b00, 2'b00, aluAdd, 2'b00), "add");
    decodeOne(rType(7'h20, 5'd6, 5'd5, 3'b000, 5'd4),
              mkCtrl(4'b1000, 2'b00, 2'b00, 2'b00, aluSub, 2'b00), "sub");
    decodeOne(rType(7'h20, 5'd9, 5'd8, 3'b101, 5'd7),
              mkCtrl(4'b1000, 2'b00, 2'b00, 2'b00, aluSra, 2'b00), "sra");
    decodeOne(iType(12'hffb, 5'd11, 3'b000, 5'd10, opOpImm),
              mkCtrl(4'b1000, 2'b01, 2'b00, 2'b00, aluAdd, 2'b00), "addi");
    decodeOne(iType(12'h008, 5'd13, 3'b010, 5'd12, opLoad),
              mkCtrl(4'b1010, 2'b01, 2'b00, 2'b10, aluAdd, 2'b01), "lw");
    decodeOne(iType(12'h001, 5'd15, 3'b100, 5'd14, opLoad),
              mkCtrl(4'b1000, 2'b01, 2'b00, 2'b00, aluAdd, 2'b01), "lbu");
    decodeOne(sType(12'h006, 5'd16, 5'd17, 3'b001),
              mkCtrl(4'b0100, 2'b01, 2'b00, 2'b01, aluAdd, 2'b00), "sh");
    decodeOne(bType(13'h1ff8, 5'd19, 5'd18, 3'b000),
              mkCtrl(4'b0000, 2'b00, 2'b01, 2'b00, aluBeq, 2'b00), "beq");
    decodeOne(bType(13'h0010, 5'd21, 5'd20, 3'b111),
              mkCtrl(4'b0000, 2'b00, 2'b01, 2'b00, aluBgeu, 2'b00), "bgeu");
    decodeOne(jType(21'h000800, 5'd1),
              mkCtrl(4'b1000, 2'b11, 2'b10, 2'b00, aluAdd, 2'b10), "jal");
    decodeOne(iType(12'h004, 5'd1, 3'b000, 5'd0, opJalr),
              mkCtrl(4'b1000, 2'b01, 2'b11, 2'b00, aluAdd, 2'b10), "jalr");
    decodeOne(uType(20'h12345, 5'd22, opLui),
              mkCtrl(4'b1000, 2'b00, 2'b00, 2'b00, aluAdd, 2'b11), "lui");
    decodeOne(uType(20'h80000, 5'd23, opAuipc),
              mkCtrl(4'b1000, 2'b11, 2'b00, 2'b00, aluAdd, 2'b00), "auipc");
    endTest("control", start);
  endtask

  task testImmediates();
    int start;
    word_t r;
    start = errors;
    for (int k = 0; k < 6; k++) begin
      r = xorshift32();
      immOne(iType(r[11:0], 5'd1, 3'b000, 5'd2, opOpImm), {{20{r[11]}}, r[11:0]}, "I imm");
      immOne(sType(r[11:0], 5'd2, 5'd1, 3'b010), {{20{r[11]}}, r[11:0]}, "S imm");
      immOne(bType(r[12:0], 5'd2, 5'd1, 3'b000), {{19{r[12]}}, r[12:1], 1'b0}, "B imm");
      immOne(uType(r[31:12], 5'd3, opLui), {r[31:12], 12'h000}, "U imm");
      immOne(jType(r[20:0], 5'd4), {{11{r[20]}}, r[20:1], 1'b0}, "J imm");
    end
    endTest("immediates", start);
  endtask

  task testStallFlush();
    int start;
    word_t held;
    start = errors;
    present(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    settle();
    held = pcCur;
    @(posedge clk);
    stallD <= 1'b1;
    instrF <= sType(12'h010, 5'd4, 5'd5, 3'b010);   // Must not get in
    pcF <= 32'h0000_0800;
    pcPlus4F <= 32'h0000_0804;
    repeat (2) @(posedge clk);
    settle();
    checkWord(pcD, held, "stall pcD");
    checkReg(rdD, 5'd3, "stall rdD");
    checkCtrl(ctrlNow(), mkCtrl(4'b1000, 2'b00, 2'b00, 2'b00, aluAdd, 2'b00), "stall");
    @(posedge clk);
    flushD <= 1'b1;                      // Stall still high
    @(posedge clk);
    flushD <= 1'b0;
    settle();
    checkBubble("stall and flush");
    @(posedge clk);
    stallD <= 1'b0;
    @(posedge clk);
    settle();
    checkWord(pcD, 32'h0000_0800, "after stall pcD");
    @(posedge clk);
    flushD <= 1'b1;
    @(posedge clk);
    flushD <= 1'b0;
    settle();
    checkBubble("flush");
    endTest("stallFlush", start);
  endtask

  task testIllegal();
    int start;
    start = errors;
    decodeOne(32'hffff_ffff, mkCtrl(4'b0001, 2'b00, 2'b00, 2'b00, aluAdd, 2'b00), "op 7f");
    decodeOne(32'h0000_0000, mkCtrl(4'b0001, 2'b00, 2'b00, 2'b00, aluAdd, 2'b00), "op 00");
    endTest("illegal", start);
  endtask

  initial begin
    rstN = 1'b0;
    instrF = nopInstr;
    pcF = '0;
    pcPlus4F = '0;
    stallD = 1'b0;
    flushD = 1'b0;
    regWriteW = 1'b0;
    rdW = '0;
    resultW = '0;
    testReset();
    testRegFile();
    testControl();
    testImmediates();
    testStallFlush();
    testIllegal();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== stageD_assert.sv ====
`timescale 1ns/1ps

module stageDAssert (
  input logic                clk,
  input logic                rstN,
  input logic                stallD,
  input logic                flushD,
  input logic                regWriteD,
  input decodePkg::word_t    pcD,
  input decodePkg::regAddr_t rs1D,
  input decodePkg::word_t    rd1D
);

  // A flushed slot never writes back
  flushKillsWrite: assert property (
    @(posedge clk) disable iff (!rstN) flushD |=> !regWriteD
  ) else $error("regWriteD high in the cycle after a flush");

  stallHoldsPc: assert property (
    @(posedge clk) disable iff (!rstN) (stallD && !flushD) |=> $stable(pcD)
  ) else $error("pcD changed in the cycle after a stall");

  zeroRegReadsZero: assert property (
    @(posedge clk) disable iff (!rstN) (rs1D == '0) |-> (rd1D == '0)
  ) else $error("x0 read returned a nonzero value");

endmodule

bind stageD stageDAssert stageDAssert_i (
  .clk       (clk),
  .rstN      (rstN),
  .stallD    (stallD),
  .flushD    (flushD),
  .regWriteD (regWriteD),
  .pcD       (pcD),
  .rs1D      (rs1D),
  .rd1D      (rd1D)
);

// ==== stageD.sv ====
`timescale 1ns/1ps

module stageD (
  input  logic                   clk,
  input  logic                   rstN,
  input  decodePkg::word_t       instrF,
  input  decodePkg::word_t       pcF,
  input  decodePkg::word_t       pcPlus4F,
  input  logic                   stallD,
  input  logic                   flushD,
  input  logic                   regWriteW,
  input  decodePkg::regAddr_t    rdW,
  input  decodePkg::word_t       resultW,
  output decodePkg::word_t       rd1D,
  output decodePkg::word_t       rd2D,
  output decodePkg::word_t       immExtD,
  output decodePkg::word_t       pcD,
  output decodePkg::word_t       pcPlus4D,
  output decodePkg::regAddr_t    rs1D,
  output decodePkg::regAddr_t    rs2D,
  output decodePkg::regAddr_t    rdD,
  output logic                   regWriteD,
  output logic                   memWriteD,
  output logic                   memSignedD,
  output logic                   illegalD,
  output decodePkg::aluSrc_t     aluSrcD,
  output decodePkg::branch_t     branchD,
  output decodePkg::memSize_t    memSizeD,
  output decodePkg::aluCtrl_t    aluControlD,
  output decodePkg::resultSrc_t  resultSrcD
);
  import decodePkg::*;

  word_t instrD;
  logic  validD;                  // Low for a bubble

  decodeCtrlIf ctrlIf ();

  // Fetch/decode register, flush beats stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD   <= nopInstr;
      pcD      <= '0;
      pcPlus4D <= '0;
      validD   <= 1'b0;
    end else if (flushD) begin
      instrD   <= nopInstr;
      pcD      <= '0;
      pcPlus4D <= '0;
      validD   <= 1'b0;
    end else if (!stallD) begin
      instrD   <= instrF;
      pcD      <= pcF;
      pcPlus4D <= pcPlus4F;
      validD   <= 1'b1;
    end
  end

  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];
  assign rdD  = instrD[11:7];

  controlDecoder controlDecoder_i (
    .instr (instrD),
    .ctrl  (ctrlIf.dec)
  );

  // Bubble kills every control, immSrc only steers the extender
  assign regWriteD   = validD & ctrlIf.regWrite;
  assign memWriteD   = validD & ctrlIf.memWrite;
  assign memSignedD  = validD & ctrlIf.memSigned;
  assign illegalD    = validD & ctrlIf.illegal;
  assign aluSrcD     = validD ? ctrlIf.aluSrc : '0;
  assign branchD     = validD ? ctrlIf.branch : '0;
  assign memSizeD    = validD ? ctrlIf.memSize : '0;
  assign aluControlD = validD ? ctrlIf.aluControl : '0;
  assign resultSrcD  = validD ? ctrlIf.resultSrc : '0;

  immExtend immExtend_i (
    .instr  (instrD),
    .immSrc (ctrlIf.immSrc),
    .immExt (immExtD)
  );

  regFile regFile_i (
    .clk  (clk),
    .rstN (rstN),
    .we3  (regWriteW),
    .wa3  (rdW),
    .wd3  (resultW),
    .ra1  (rs1D),
    .ra2  (rs2D),
    .rd1  (rd1D),
    .rd2  (rd2D)
  );

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 we3,
  input  decodePkg::regAddr_t  wa3,
  input  decodePkg::word_t     wd3,
  input  decodePkg::regAddr_t  ra1,
  input  decodePkg::regAddr_t  ra2,
  output decodePkg::word_t     rd1,
  output decodePkg::word_t     rd2
);
  import decodePkg::*;

  word_t regs [32];

  // Falling edge write, so same-cycle reads see the new value
  always_ff @(negedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we3 && (wa3 != '0)) begin
      regs[wa3] <= wd3;           // x0 never written
    end
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== immExtend.sv ====
`timescale 1ns/1ps

module immExtend (
  input  decodePkg::word_t   instr,
  input  decodePkg::immSrc_t immSrc,
  output decodePkg::word_t   immExt
);
  import decodePkg::*;

  logic sign;

  assign sign = instr[31];

  always_comb begin
    case (immSrc)
      immI: begin
        immExt = {{20{sign}}, instr[31:20]};
      end
      immS: begin
        immExt = {{20{sign}}, instr[31:25], instr[11:7]};
      end
      immB: begin
        // Offset in halfwords, bit 0 forced low
        immExt = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      immU: begin
        immExt = {instr[31:12], 12'b0};
      end
      immJ: begin
        immExt = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        immExt = '0;              // Unused select codes
      end
    endcase
  end

endmodule

// ==== controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder (
  input decodePkg::word_t instr,
  decodeCtrlIf.dec        ctrl
);
  import decodePkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  aluCtrl_t   arithCode;
  aluCtrl_t   cmpCode;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  // Arithmetic op from funct3, bit 30 picks sub or sra
  always_comb begin
    case (funct3)
      3'b000: begin
        // addi has no sub form, bit 30 is part of its immediate
        arithCode = (opcode == opOp && funct7b5) ? aluSub : aluAdd;
      end
      3'b001:  arithCode = aluSll;
      3'b010:  arithCode = aluSlt;
      3'b011:  arithCode = aluSltu;
      3'b100:  arithCode = aluXor;
      3'b101:  arithCode = funct7b5 ? aluSra : aluSrl;
      3'b110:  arithCode = aluOr;
      default: arithCode = aluAnd;
    endcase
  end

  // Branch compare kind
  always_comb begin
    case (funct3)
      3'b001:  cmpCode = aluBne;
      3'b100:  cmpCode = aluBlt;
      3'b101:  cmpCode = aluBge;
      3'b110:  cmpCode = aluBltu;
      3'b111:  cmpCode = aluBgeu;
      default: cmpCode = aluBeq;    // Also reserved 010/011
    endcase
  end

  always_comb begin
    ctrl.regWrite   = 1'b0;
    ctrl.memWrite   = 1'b0;
    ctrl.aluSrc     = 2'b00;
    ctrl.branch     = 2'b00;
    ctrl.memSize    = 2'b00;
    ctrl.memSigned  = 1'b0;
    ctrl.aluControl = aluAdd;
    ctrl.resultSrc  = 2'b00;
    ctrl.immSrc     = immI;
    ctrl.illegal    = 1'b0;

    case (opcode)
      opOp: begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluControl = arithCode;
      end
      opOpImm: begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluSrc     = 2'b01;    // rs1 op imm
        ctrl.aluControl = arithCode;
      end
      opLoad: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrc    = 2'b01;     // Address rs1 + imm
        ctrl.resultSrc = 2'b01;     // From memory
        ctrl.memSize   = funct3[1:0];
        ctrl.memSigned = ~funct3[2];
      end
      opStore: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 2'b01;
        ctrl.immSrc   = immS;
        ctrl.memSize  = funct3[1:0];
      end
      opBranch: begin
        ctrl.branch     = 2'b01;    // Conditional
        ctrl.immSrc     = immB;
        ctrl.aluControl = cmpCode;
      end
      opJal: begin
        ctrl.regWrite  = 1'b1;
        ctrl.branch    = 2'b10;
        ctrl.aluSrc    = 2'b11;     // Target PC + imm
        ctrl.immSrc    = immJ;
        ctrl.resultSrc = 2'b10;     // Link PC+4
      end
      opJalr: begin
        ctrl.regWrite  = 1'b1;
        ctrl.branch    = 2'b11;
        ctrl.aluSrc    = 2'b01;     // Target rs1 + imm
        ctrl.resultSrc = 2'b10;
      end
      opLui: begin
        ctrl.regWrite  = 1'b1;
        ctrl.immSrc    = immU;
        ctrl.resultSrc = 2'b11;     // Immediate straight through
      end
      opAuipc: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 2'b11;      // PC + imm
        ctrl.immSrc   = immU;
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== decodeCtrlIf.sv ====
`timescale 1ns/1ps

interface decodeCtrlIf;
  import decodePkg::*;

  logic       regWrite;
  logic       memWrite;
  aluSrc_t    aluSrc;
  branch_t    branch;
  memSize_t   memSize;
  logic       memSigned;   // Load sign extension
  aluCtrl_t   aluControl;
  resultSrc_t resultSrc;
  immSrc_t    immSrc;
  logic       illegal;     // Unknown opcode

  modport dec (
    output regWrite, memWrite, aluSrc, branch, memSize,
    output memSigned, aluControl, resultSrc, immSrc, illegal
  );

  modport stage (
    input regWrite, memWrite, aluSrc, branch, memSize,
    input memSigned, aluControl, resultSrc, immSrc, illegal
  );

endinterface

// ==== decodePkg.sv ====
package decodePkg;

  typedef logic [31:0] word_t;       // Data, PC or instruction word
  typedef logic [4:0]  regAddr_t;    // Register index
  typedef logic [4:0]  aluCtrl_t;    // ALU operation code
  typedef logic [2:0]  immSrc_t;     // Immediate format select
  typedef logic [1:0]  resultSrc_t;  // Writeback source
  typedef logic [1:0]  branch_t;     // Branch kind
  typedef logic [1:0]  aluSrc_t;     // Bit 0 imm as B, bit 1 PC as A
  typedef logic [1:0]  memSize_t;    // Byte, half, word

  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;

  localparam aluCtrl_t aluAdd  = 5'd0;
  localparam aluCtrl_t aluSub  = 5'd1;
  localparam aluCtrl_t aluSll  = 5'd2;
  localparam aluCtrl_t aluSlt  = 5'd3;
  localparam aluCtrl_t aluSltu = 5'd4;
  localparam aluCtrl_t aluXor  = 5'd5;
  localparam aluCtrl_t aluSrl  = 5'd6;
  localparam aluCtrl_t aluSra  = 5'd7;
  localparam aluCtrl_t aluOr   = 5'd8;
  localparam aluCtrl_t aluAnd  = 5'd9;
  localparam aluCtrl_t aluBeq  = 5'd10; // Branch compares
  localparam aluCtrl_t aluBne  = 5'd11;
  localparam aluCtrl_t aluBlt  = 5'd12;
  localparam aluCtrl_t aluBge  = 5'd13;
  localparam aluCtrl_t aluBltu = 5'd14;
  localparam aluCtrl_t aluBgeu = 5'd15;

  localparam immSrc_t immI = 3'd0;
  localparam immSrc_t immS = 3'd1;
  localparam immSrc_t immB = 3'd2;
  localparam immSrc_t immU = 3'd3;
  localparam immSrc_t immJ = 3'd4;

  localparam word_t nopInstr = 32'h0000_0013; // addi x0,x0,0

endpackage
